//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TOP        ?= tb_sa
LINT_TOP   ?= sa_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- common/sa_pkg.sv
package sa_pkg;

    // array geometry and arithmetic widths
    localparam int PE_SIZE    = 4;
    localparam int DATA_WIDTH = 8;
    localparam int PSUM_WIDTH = 32;

    // ctrl register, input skew, array traversal, output deskew
    localparam int RESULT_LAT = 2 * PE_SIZE + 1;

    localparam int LAT_W  = $clog2(RESULT_LAT + 1);
    localparam int WCNT_W = $clog2(PE_SIZE + 1);

    // skew_buffer direction
    localparam bit SKEW_STAGGER = 1'b0;
    localparam bit SKEW_ALIGN   = 1'b1;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    typedef enum logic {
        CMD_WEIGHT = 1'b0,
        CMD_IFMAP  = 1'b1
    } cmd_kind_e;

    // one host word, read as weights per column or activations per array row
    typedef union packed {
        data_t [PE_SIZE-1:0] weight_row;
        data_t [PE_SIZE-1:0] ifmap_row;
    } row_word_u;

    typedef struct packed {
        cmd_kind_e kind;
        row_word_u word;
    } cmd_t;

    // element j holds the sum of column j
    typedef psum_t [PE_SIZE-1:0] result_t;

    typedef struct packed {
        logic  weight_shift;
        logic  ifmap_en;
        data_t ifmap;
    } pe_ctl_t;

endpackage

//--- design/sa_ctrl.sv
module sa_ctrl (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              cmd_valid_i,
    input  sa_pkg::cmd_kind_e cmd_kind_i,
    input  sa_pkg::row_word_u cmd_word_i,
    input  logic              in_flight_i,
    output logic              weight_shift_o,
    output logic              ifmap_accept_o,
    output logic              drop_o,
    output sa_pkg::row_word_u row_word_o
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_LOADING,
        ST_READY
    } state_e;

    state_e                    state_q;
    state_e                    state_d;
    logic [sa_pkg::WCNT_W-1:0] wcnt_q;
    logic [sa_pkg::WCNT_W-1:0] wcnt_d;
    logic [sa_pkg::WCNT_W-1:0] wcnt_base;
    logic                      shift_d;
    logic                      accept_d;
    logic                      drop_d;
    logic                      wt_blocked;

    // accept register covers the cycle before the timer is loaded
    assign wt_blocked = in_flight_i || ifmap_accept_o;

    // a new load after READY counts from one again
    assign wcnt_base = (state_q == ST_READY) ? '0 : wcnt_q;

    always_comb begin
        state_d  = state_q;
        wcnt_d   = wcnt_q;
        shift_d  = 1'b0;
        accept_d = 1'b0;
        drop_d   = 1'b0;
        if (cmd_valid_i) begin
            if (cmd_kind_i == sa_pkg::CMD_WEIGHT) begin
                if (wt_blocked) begin
                    drop_d = 1'b1;
                end else begin
                    shift_d = 1'b1;
                    wcnt_d  = wcnt_base + 1'b1;
                    if (wcnt_d == sa_pkg::WCNT_W'(sa_pkg::PE_SIZE)) begin
                        state_d = ST_READY;
                    end else begin
                        state_d = ST_LOADING;
                    end
                end
            end else if (state_q == ST_READY) begin
                accept_d = 1'b1;
            end else begin
                // array not fully loaded
                drop_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= ST_EMPTY;
            wcnt_q         <= '0;
            weight_shift_o <= 1'b0;
            ifmap_accept_o <= 1'b0;
            drop_o         <= 1'b0;
        end else begin
            state_q        <= state_d;
            wcnt_q         <= wcnt_d;
            weight_shift_o <= shift_d;
            ifmap_accept_o <= accept_d;
            drop_o         <= drop_d;
        end
    end

    // row word lines up with the registered strobes
    always_ff @(posedge clk) begin
        if (cmd_valid_i) begin
            row_word_o <= cmd_word_i;
        end
    end

endmodule

//--- design/sa_timer.sv
module sa_timer (
    input  logic clk,
    input  logic arst_n_i,
    input  logic load_i,
    output logic active_o
);

    logic [sa_pkg::LAT_W-1:0] cnt_q;

    // each load restarts the window, so overlapping rows extend it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= sa_pkg::LAT_W'(sa_pkg::RESULT_LAT);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    assign active_o = (cnt_q != '0);

endmodule

//--- design/sa_top.sv
module sa_top (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            cmd_valid_i,
    input  sa_pkg::cmd_t    cmd_i,
    output logic            result_valid_o,
    output sa_pkg::result_t result_o,
    output logic            drop_o,
    output logic            busy_o
);

    logic                                  weight_shift;
    logic                                  ifmap_accept;
    sa_pkg::row_word_u                     row_word;
    sa_pkg::pe_ctl_t [sa_pkg::PE_SIZE-1:0] ifmap_lane;
    sa_pkg::result_t                       psum_col;
    logic [sa_pkg::PE_SIZE-1:0]            psum_en;

    sa_ctrl u_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_kind_i     (cmd_i.kind),
        .cmd_word_i     (cmd_i.word),
        .in_flight_i    (busy_o),
        .weight_shift_o (weight_shift),
        .ifmap_accept_o (ifmap_accept),
        .drop_o         (drop_o),
        .row_word_o     (row_word)
    );

    sa_timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .load_i   (ifmap_accept),
        .active_o (busy_o)
    );

    // row i of the activation word enters i cycles after row 0
    skew_buffer #(.DIR(sa_pkg::SKEW_STAGGER)) u_skew_in (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (ifmap_accept),
        .data_i   (row_word),
        .valid_o  (),
        .data_o   (ifmap_lane)
    );

    pe_array u_array (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .weight_shift_i (weight_shift),
        .weight_row_i   (row_word),
        .ifmap_lane_i   (ifmap_lane),
        .psum_col_o     (psum_col),
        .psum_en_o      (psum_en)
    );

    skew_buffer #(.DIR(sa_pkg::SKEW_ALIGN)) u_skew_out (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (psum_en),
        .data_i   (psum_col),
        .valid_o  (result_valid_o),
        .data_o   (result_o)
    );

endmodule

//--- design/skew_buffer.sv
module skew_buffer #(
    parameter bit DIR  = sa_pkg::SKEW_STAGGER,
    parameter int VI_W = (DIR == sa_pkg::SKEW_ALIGN) ? sa_pkg::PE_SIZE : 1,
    parameter int DI_W = (DIR == sa_pkg::SKEW_ALIGN) ? $bits(sa_pkg::result_t)
                                                     : $bits(sa_pkg::row_word_u),
    parameter int DO_W = (DIR == sa_pkg::SKEW_ALIGN) ? $bits(sa_pkg::result_t)
                                                     : sa_pkg::PE_SIZE * $bits(sa_pkg::pe_ctl_t)
) (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic [VI_W-1:0] valid_i,
    input  logic [DI_W-1:0] data_i,
    output logic            valid_o,
    output logic [DO_W-1:0] data_o
);

    localparam int N  = sa_pkg::PE_SIZE;
    localparam int LW = (DIR == sa_pkg::SKEW_ALIGN) ? sa_pkg::PSUM_WIDTH : sa_pkg::DATA_WIDTH;

    logic [N-1:0]         lane_vld_in;
    logic [N-1:0]         lane_vld_out;
    logic [N-1:0][LW-1:0] lane_dat_in;
    logic [N-1:0][LW-1:0] lane_dat_out;

    // lane n: n+1 stages when staggering, N-n stages when aligning
    for (genvar n = 0; n < N; n++) begin : gen_lane
        localparam int DEPTH = (DIR == sa_pkg::SKEW_ALIGN) ? N - n : n + 1;

        logic [DEPTH-1:0]         vld_sr;
        logic [DEPTH-1:0][LW-1:0] dat_sr;

        always_ff @(posedge clk or negedge arst_n_i) begin
            if (!arst_n_i) begin
                vld_sr <= '0;
            end else begin
                vld_sr[0] <= lane_vld_in[n];
                for (int k = 1; k < DEPTH; k++) begin
                    vld_sr[k] <= vld_sr[k-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            dat_sr[0] <= lane_dat_in[n];
            for (int k = 1; k < DEPTH; k++) begin
                dat_sr[k] <= dat_sr[k-1];
            end
        end

        assign lane_vld_out[n] = vld_sr[DEPTH-1];
        assign lane_dat_out[n] = dat_sr[DEPTH-1];
    end

    if (DIR == sa_pkg::SKEW_STAGGER) begin : gen_stagger
        sa_pkg::row_word_u                   word;
        sa_pkg::pe_ctl_t [N-1:0]             ctl;

        assign word = data_i;
        for (genvar n = 0; n < N; n++) begin : gen_map
            assign lane_vld_in[n] = valid_i[0];
            assign lane_dat_in[n] = word.ifmap_row[n];
            assign ctl[n] = '{weight_shift: 1'b0, ifmap_en: lane_vld_out[n],
                              ifmap: lane_dat_out[n]};
        end
        assign data_o = ctl;
        // last array row has received its activation
        assign valid_o = lane_vld_out[N-1];
    end else begin : gen_align
        sa_pkg::result_t sums_in;
        sa_pkg::result_t sums_out;

        assign sums_in = data_i;
        for (genvar n = 0; n < N; n++) begin : gen_map
            assign lane_vld_in[n] = valid_i[n];
            assign lane_dat_in[n] = sums_in[n];
            assign sums_out[n]    = lane_dat_out[n];
        end
        assign data_o  = sums_out;
        assign valid_o = &lane_vld_out;
    end

endmodule

//--- pe_array/pe.sv
module pe (
    input  logic            clk,
    input  logic            arst_n_i,
    input  sa_pkg::pe_ctl_t ctl_i,
    input  sa_pkg::data_t   weight_i,
    input  sa_pkg::psum_t   psum_i,
    input  logic            psum_en_i,
    output sa_pkg::pe_ctl_t ctl_o,
    output sa_pkg::data_t   weight_o,
    output sa_pkg::psum_t   psum_o,
    output logic            psum_en_o
);

    sa_pkg::data_t                          weight_q;
    sa_pkg::data_t                          ifmap_q;
    logic                                   en_q;
    sa_pkg::psum_t                          psum_q;
    sa_pkg::psum_t                          psum_in;
    logic signed [2*sa_pkg::DATA_WIDTH-1:0] prod;

    // full signed product, sign extended by the add below
    assign prod = ctl_i.ifmap * weight_q;

    // top row has nothing above it
    assign psum_in = psum_en_i ? psum_i : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            weight_q <= '0;
            en_q     <= 1'b0;
        end else begin
            if (ctl_i.weight_shift) begin
                weight_q <= weight_i;
            end
            en_q <= ctl_i.ifmap_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ctl_i.ifmap_en) begin
            ifmap_q <= ctl_i.ifmap;
            psum_q  <= psum_in + prod;
        end
    end

    // shift strobe reaches the whole row in one cycle
    assign ctl_o = '{weight_shift: ctl_i.weight_shift, ifmap_en: en_q, ifmap: ifmap_q};

    assign weight_o  = weight_q;
    assign psum_o    = psum_q;
    assign psum_en_o = en_q;

endmodule

//--- pe_array/pe_array.sv
module pe_array (
    input  logic                                   clk,
    input  logic                                   arst_n_i,
    input  logic                                   weight_shift_i,
    input  sa_pkg::row_word_u                      weight_row_i,
    input  sa_pkg::pe_ctl_t [sa_pkg::PE_SIZE-1:0]  ifmap_lane_i,
    output sa_pkg::result_t                        psum_col_o,
    output logic [sa_pkg::PE_SIZE-1:0]             psum_en_o
);

    localparam int N = sa_pkg::PE_SIZE;

    // ctl runs left to right, one extra column at the right edge
    sa_pkg::pe_ctl_t ctl_w    [N][N+1];
    // weights and sums run top to bottom, one extra row at the bottom
    sa_pkg::data_t   wgt_w    [N+1][N];
    sa_pkg::psum_t   psum_w   [N+1][N];
    logic            psum_en_w[N+1][N];

    for (genvar i = 0; i < N; i++) begin : gen_left_edge
        assign ctl_w[i][0] = '{
            weight_shift: weight_shift_i,
            ifmap_en:     ifmap_lane_i[i].ifmap_en,
            ifmap:        ifmap_lane_i[i].ifmap
        };
    end

    for (genvar j = 0; j < N; j++) begin : gen_top_edge
        // new weight row enters array row 0
        assign wgt_w[0][j]     = weight_row_i.weight_row[j];
        // every column starts from zero
        assign psum_w[0][j]    = '0;
        assign psum_en_w[0][j] = 1'b0;
    end

    for (genvar i = 0; i < N; i++) begin : gen_row
        for (genvar j = 0; j < N; j++) begin : gen_col
            pe u_pe (
                .clk       (clk),
                .arst_n_i  (arst_n_i),
                .ctl_i     (ctl_w[i][j]),
                .weight_i  (wgt_w[i][j]),
                .psum_i    (psum_w[i][j]),
                .psum_en_i (psum_en_w[i][j]),
                .ctl_o     (ctl_w[i][j+1]),
                .weight_o  (wgt_w[i+1][j]),
                .psum_o    (psum_w[i+1][j]),
                .psum_en_o (psum_en_w[i+1][j])
            );
        end
    end

    for (genvar j = 0; j < N; j++) begin : gen_bottom_edge
        assign psum_col_o[j] = psum_w[N][j];
        assign psum_en_o[j]  = psum_en_w[N][j];
    end

endmodule

//--- tb.f
common/sa_pkg.sv
pe_array/pe.sv
pe_array/pe_array.sv
design/skew_buffer.sv
design/sa_timer.sv
design/sa_ctrl.sv
design/sa_top.sv
tests/sa_sva.sv
tests/tb_sa.sv

//--- tests/sa_patterns.txt
// test  kind  row word  idle gap
// kind 0 weight row, 1 activation row, 2 reset; a test number of ff ends the list
1 1 01020304 2
1 1 fffefdfc 3
2 0 04030201 0
2 0 08070605 0
2 0 0c0b0a09 0
2 0 100f0e0d 1
2 1 01010101 12
2 1 ff02fe03 12
3 1 01020304 0
3 1 05060708 0
3 1 fffefdfc 0
3 1 7f807f80 12
4 1 02030405 2
4 0 11111111 0
4 1 0a0b0c0d 5
4 0 22222222 12
4 1 01010101 12
5 0 80ff7f01 0
5 0 fe81027f 0
5 0 fffffffe 0
5 0 01807ffd 1
5 1 807f80ff 12
5 1 ff81ff80 12
6 2 00000000 3
6 1 01020304 3
6 0 01010101 0
6 0 02020202 0
6 0 03030303 0
6 0 04040404 1
6 1 01020304 12
ff 0 00000000 0

//--- tests/sa_sva.sv
module sa_sva (
    input logic clk,
    input logic arst_n_i,
    input logic result_valid_i,
    input logic drop_i,
    input logic busy_i
);

    // number of failed assertions so far
    int fail_cnt = 0;

    // outputs stay quiet while reset is held
    no_result_in_reset: assert property (@(posedge clk) !arst_n_i |-> !result_valid_i)
        else begin
            $error("result_valid_o high during reset");
            fail_cnt++;
        end

    busy_with_result: assert property (@(posedge clk) disable iff (!arst_n_i)
        result_valid_i |-> busy_i)
        else begin
            $error("result_valid_o high while busy_o is low");
            fail_cnt++;
        end

    // a dropped command never comes back as a result row
    no_result_after_drop: assert property (@(posedge clk) disable iff (!arst_n_i)
        drop_i |-> ##(sa_pkg::RESULT_LAT) !result_valid_i)
        else begin
            $error("result_valid_o for a dropped command");
            fail_cnt++;
        end

endmodule

bind sa_top sa_sva u_sva (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .result_valid_i (result_valid_o),
    .drop_i         (drop_o),
    .busy_i         (busy_o)
);

//--- tests/tb_sa.sv
module tb_sa;

    localparam int RST_CYCLES = 16;
    localparam int MAX_CMDS   = 64;
    localparam int JITTER_MIN = 3;
    localparam int END_MARK   = 'hff;

    logic              clk;
    logic              arst_n_i;
    logic              cmd_valid_i;
    sa_pkg::cmd_t      cmd_i;
    logic              result_valid_o;
    sa_pkg::result_t   result_o;
    logic              drop_o;
    logic              busy_o;

    logic [31:0]       pat_mem [0:4*MAX_CMDS-1];
    // reference copy of the weight rows indexed by array row
    sa_pkg::row_word_u w_rows [sa_pkg::PE_SIZE];
    sa_pkg::result_t   exp_q [$];
    int                due_q [$];
    int                acc_q [$];
    int                cycle;
    int                drop_due;
    int                wcount;
    bit                ready;
    int                seed;
    int                limit_cycles;
    int                cur_test;
    int                test_errs;
    int                err_count;
    int                check_count;
    int                tests_run;
    int                tests_failed;
    int                sva_seen;

    sa_top dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_i          (cmd_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .drop_o         (drop_o),
        .busy_o         (busy_o)
    );

    always #5 clk = ~clk;

    // column j is the sum over array rows of activation times weight
    function automatic sa_pkg::result_t expected_sums(input sa_pkg::row_word_u act);
        sa_pkg::result_t sums;
        sums = '0;
        for (int j = 0; j < sa_pkg::PE_SIZE; j++) begin
            for (int i = 0; i < sa_pkg::PE_SIZE; i++) begin
                sums[j] = sums[j] + sa_pkg::psum_t'(act.ifmap_row[i])
                                  * sa_pkg::psum_t'(w_rows[i].weight_row[j]);
            end
        end
        return sums;
    endfunction

    function automatic bit accepted_within(input int at, input int lo, input int hi);
        bit hit;
        hit = 1'b0;
        foreach (acc_q[n]) begin
            if (at - acc_q[n] >= lo && at - acc_q[n] <= hi) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic note_error();
        err_count++;
        test_errs++;
    endtask

    task automatic check_result(input logic exp_vld, input sa_pkg::result_t exp,
                                input logic act_vld, input sa_pkg::result_t act);
        check_count++;
        if (exp_vld !== act_vld) begin
            $display("[FAIL] t=%0t result_valid_o expected %b got %b", $time, exp_vld, act_vld);
            note_error();
        end else if (exp_vld && exp !== act) begin
            $display("[FAIL] t=%0t result_o expected %h got %h", $time, exp, act);
            note_error();
        end
    endtask

    task automatic check_drop(input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            $display("[FAIL] t=%0t drop_o expected %b got %b", $time, exp, act);
            note_error();
        end
    endtask

    task automatic check_busy(input logic exp, input logic act);
        check_count++;
        if (exp !== act) begin
            $display("[FAIL] t=%0t busy_o expected %b got %b", $time, exp, act);
            note_error();
        end
    endtask

    // one clock with outputs compared at the falling edge where they are stable
    task automatic tick();
        sa_pkg::result_t exp;
        logic            exp_vld;
        @(negedge clk);
        cycle++;
        exp     = '0;
        exp_vld = 1'b0;
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            exp_vld = 1'b1;
            exp     = exp_q.pop_front();
            void'(due_q.pop_front());
        end
        check_result(exp_vld, exp, result_valid_o, result_o);
        check_drop(drop_due == cycle, drop_o);
        // busy from the cycle after the timer load until it expires
        check_busy(accepted_within(cycle, 2, sa_pkg::RESULT_LAT + 1), busy_o);
        while (acc_q.size() > 0 && cycle - acc_q[0] > sa_pkg::RESULT_LAT + 1) begin
            void'(acc_q.pop_front());
        end
    endtask

    task automatic send_cmd(input sa_pkg::cmd_kind_e cmd_kind, input sa_pkg::row_word_u row_word);
        cmd_valid_i = 1'b1;
        cmd_i       = '{kind: cmd_kind, word: row_word};
        if (cmd_kind == sa_pkg::CMD_WEIGHT) begin
            // in flight counts from the registered accept onwards
            if (accepted_within(cycle, 1, sa_pkg::RESULT_LAT + 1)) begin
                drop_due = cycle + 1;
            end else begin
                for (int i = sa_pkg::PE_SIZE - 1; i > 0; i--) begin
                    w_rows[i] = w_rows[i-1];
                end
                w_rows[0] = row_word;
                wcount    = ready ? 1 : wcount + 1;
                ready     = (wcount == sa_pkg::PE_SIZE);
            end
        end else if (ready) begin
            acc_q.push_back(cycle);
            exp_q.push_back(expected_sums(row_word));
            due_q.push_back(cycle + sa_pkg::RESULT_LAT + 1);
        end else begin
            drop_due = cycle + 1;
        end
        tick();
        cmd_valid_i = 1'b0;
    endtask

    task automatic apply_reset();
        arst_n_i = 1'b0;
        for (int i = 0; i < sa_pkg::PE_SIZE; i++) begin
            w_rows[i] = '0;
        end
        wcount   = 0;
        ready    = 1'b0;
        drop_due = -1;
        acc_q.delete();
        exp_q.delete();
        due_q.delete();
        repeat (RST_CYCLES) tick();
        arst_n_i = 1'b1;
    endtask

    // let every pending result, drop and busy window run out
    task automatic drain();
        while (due_q.size() > 0 || drop_due > cycle
               || accepted_within(cycle, 0, sa_pkg::RESULT_LAT + 1)) begin
            tick();
        end
    endtask

    task automatic finish_test();
        int sva_now;
        drain();
        // assertion failures raised during this test
        sva_now   = dut0.u_sva.fail_cnt;
        test_errs = test_errs + (sva_now - sva_seen);
        err_count = err_count + (sva_now - sva_seen);
        sva_seen  = sva_now;
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %0d: failed with %0d errors", cur_test, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int n_cmds;
        int max_gap;
        int gap;
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        seed        = 32'h6e651658;
        cycle       = 0;
        drop_due    = -1;
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
        tests_run   = 0;
        tests_failed = 0;
        sva_seen    = 0;
        $readmemh("tests/sa_patterns.txt", pat_mem);
        n_cmds  = 0;
        max_gap = 0;
        while (n_cmds < MAX_CMDS && pat_mem[4*n_cmds] !== END_MARK) begin
            if (pat_mem[4*n_cmds+3] > max_gap) begin
                max_gap = pat_mem[4*n_cmds+3];
            end
            n_cmds++;
        end
        // per command its gap with jitter, a possible reset and the result latency
        limit_cycles = n_cmds * (max_gap + JITTER_MIN + RST_CYCLES + sa_pkg::RESULT_LAT) + 100;
        cur_test = pat_mem[0];
        apply_reset();
        for (int idx = 0; idx < n_cmds; idx++) begin
            if (pat_mem[4*idx] != cur_test) begin
                finish_test();
                cur_test = pat_mem[4*idx];
            end
            if (pat_mem[4*idx+1] == 2) begin
                apply_reset();
            end else begin
                send_cmd(sa_pkg::cmd_kind_e'(pat_mem[4*idx+1][0]), pat_mem[4*idx+2]);
            end
            gap = pat_mem[4*idx+3];
            // short gaps set up the timing cases so only long idle stretches get jitter
            if (gap >= JITTER_MIN) begin
                gap = gap + ($random(seed) & 32'h3);
            end
            repeat (gap) tick();
        end
        finish_test();
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, err_count, sva_seen);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not complete", limit_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule
